//--- forthPcUnit.f
+incdir+bench
design/pcAddrPkg.sv
design/pcCtrlPkg.sv
design/pcCtrlIf.sv
design/pcVectorRegs.sv
design/programCounter.sv
design/forthPcUnit.sv
bench/forthPcUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the forthPcUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module forthPcUnitTb -f forthPcUnit.f -o forthPcUnitSim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/forthPcUnitSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

//--- bench/pcBenchTasks.svh
`ifndef PC_BENCH_TASKS_SVH
`define PC_BENCH_TASKS_SVH

// Inputs change 2 ns after the rising edge
task automatic nextCycle();
	@(posedge CLK);
	#2;
endtask

task automatic idleInputs();
	pcEn = 1'b0;
	fetch = 1'b0;
	ldInt0 = 1'b0;
	ldInt1 = 1'b0;
	baseSel = BASE_PC;
	offsetSel = OFFSET_TWO;
	nextSel = NEXT_SEQ;
	operand = '0;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = '0;
	pwdata = '0;
endtask

// One enabled fetch edge
task automatic fetchStep(input baseSelT b, input offsetSelT o, input nextSelT n,
		input pcAddrT opnd, input logic l0, input logic l1);
	pcEn = 1'b1;
	fetch = 1'b1;
	baseSel = b;
	offsetSel = o;
	nextSel = n;
	operand = opnd;
	ldInt0 = l0;
	ldInt1 = l1;
	nextCycle();
	pcEn = 1'b0;
	fetch = 1'b0;
	ldInt0 = 1'b0;
	ldInt1 = 1'b0;
endtask

// Jump and both loads set up, but an enable is low
task automatic stallStep(input logic en, input logic fe);
	pcEn = en;
	fetch = fe;
	baseSel = BASE_ZERO;
	offsetSel = OFFSET_OPERAND;
	nextSel = NEXT_INTV0;
	operand = pcAddrT'($random(seed));
	ldInt0 = 1'b1;
	ldInt1 = 1'b1;
	nextCycle();
	idleInputs();
endtask

task automatic apbWrite(input apbAddrT addr, input apbDataT data, output logic err);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b1;
	paddr = addr;
	pwdata = data;
	nextCycle();
	penable = 1'b1;
	@(negedge CLK);
	while (!pready) @(negedge CLK);
	err = pslverr;
	nextCycle();
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic apbRead(input apbAddrT addr, output apbDataT data, output logic err);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = addr;
	nextCycle();
	penable = 1'b1;
	@(negedge CLK);
	while (!pready) @(negedge CLK);
	data = prdata;
	err = pslverr;
	nextCycle();
	psel = 1'b0;
	penable = 1'b0;
endtask

task automatic checkValue(input string what, input pcAddrT got, input pcAddrT want);
	assert (got == want)
	else begin
		$display("Fail %0t: %s is %h, expected %h", $time, what, got, want);
		errors++;
	end
endtask

task automatic checkFlag(input string what, input logic got, input logic want);
	assert (got == want)
	else begin
		$display("Fail %0t: %s is %b, expected %b", $time, what, got, want);
		errors++;
	end
endtask

`endif

//--- bench/forthPcUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module forthPcUnitTb
	import pcAddrPkg::*, pcCtrlPkg::*;
();

	// Well above the cycles the stimulus takes
	localparam int TIMEOUT_CYCLES = 400;

	logic CLK = 1'b0;
	logic rstN;
	logic pcEn;
	logic fetch;
	logic ldInt0;
	logic ldInt1;
	baseSelT baseSel;
	offsetSelT offsetSel;
	nextSelT nextSel;
	pcAddrT operand;
	pcAddrT pcA;
	pcAddrT pcANext;
	logic psel;
	logic penable;
	logic pwrite;
	apbAddrT paddr;
	apbDataT pwdata;
	apbDataT prdata;
	logic pready;
	logic pslverr;

	int errors = 0;
	int cycles = 0;
	integer seed;

	// Reference model
	pcAddrT modelPc;
	pcAddrT modelRet0;
	pcAddrT modelRet1;
	pcAddrT modelVec0;
	pcAddrT modelVec1;
	pcAddrT expSum;
	pcAddrT expNext;
	apbDataT expRead;
	logic expErr;
	logic apbAccess;

	`include "pcBenchTasks.svh"

	forthPcUnit dut_i (
		.CLK(CLK), .rstN(rstN), .pcEn(pcEn), .fetch(fetch),
		.ldInt0(ldInt0), .ldInt1(ldInt1), .baseSel(baseSel), .offsetSel(offsetSel),
		.nextSel(nextSel), .operand(operand), .pcA(pcA), .pcANext(pcANext),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #10 CLK = ~CLK;

	assign apbAccess = psel && penable;
	assign expSum = (baseSel == BASE_ZERO ? 16'h0000 : modelPc)
		+ (offsetSel == OFFSET_OPERAND ? operand : 16'h0002);
	assign expErr = apbAccess && (!(paddr inside {REG_VEC0, REG_VEC1, REG_RET0, REG_RET1})
		|| (pwrite && (paddr == REG_RET0 || paddr == REG_RET1)));

	always_comb begin
		case (nextSel)
			NEXT_INTV0: expNext = modelVec0;
			NEXT_INTV1: expNext = modelVec1;
			NEXT_INTR0: expNext = modelRet0;
			NEXT_INTR1: expNext = modelRet1;
			default: expNext = expSum;
		endcase
	end

	always_comb begin
		expRead = '0;
		if (apbAccess && !pwrite) begin
			case (paddr)
				REG_VEC0: expRead = modelVec0;
				REG_VEC1: expRead = modelVec1;
				REG_RET0: expRead = modelRet0;
				REG_RET1: expRead = modelRet1;
				default: expRead = '0;
			endcase
		end
	end

	always @(posedge CLK) begin
		if (!rstN) begin
			modelPc <= '0;
			modelRet0 <= '0;
			modelRet1 <= '0;
			modelVec0 <= VEC0_RESET;
			modelVec1 <= VEC1_RESET;
		end else begin
			if (pcEn && fetch) begin
				modelPc <= expNext;
				if (ldInt0) modelRet0 <= expSum;
				if (ldInt1) modelRet1 <= expSum;
			end
			if (apbAccess && pwrite && paddr == REG_VEC0) modelVec0 <= pwdata & 16'hFFFE;
			if (apbAccess && pwrite && paddr == REG_VEC1) modelVec1 <= pwdata & 16'hFFFE;
		end
	end

	assert property (@(posedge CLK) disable iff (!rstN) pcA == modelPc)
	else begin
		$display("Fail %0t: pcA is %h, model has %h", $time, $sampled(pcA), $sampled(modelPc));
		errors++;
	end

	assert property (@(posedge CLK) disable iff (!rstN) pcANext == expNext)
	else begin
		$display("Fail %0t: pcANext is %h, expected %h", $time, $sampled(pcANext),
			$sampled(expNext));
		errors++;
	end

	assert property (@(posedge CLK) pready == apbAccess)
	else begin
		$display("Fail %0t: pready does not follow the access phase", $time);
		errors++;
	end

	assert property (@(posedge CLK) pslverr == expErr)
	else begin
		$display("Fail %0t: pslverr is %b, expected %b", $time, $sampled(pslverr),
			$sampled(expErr));
		errors++;
	end

	assert property (@(posedge CLK) prdata == expRead)
	else begin
		$display("Fail %0t: prdata is %h, expected %h", $time, $sampled(prdata),
			$sampled(expRead));
		errors++;
	end

	// Write a vector, read it back, enter and leave at that level
	task automatic vectorCheck(input apbAddrT addr, input nextSelT enter, input nextSelT leave,
			input logic lvl1);
		pcAddrT wdata;
		apbDataT rdata;
		logic err;
		wdata = pcAddrT'($random(seed));
		apbWrite(addr, wdata, err);
		checkFlag("pslverr on vector write", err, 1'b0);
		apbRead(addr, rdata, err);
		checkValue("vector readback", rdata, wdata & 16'hFFFE);
		fetchStep(BASE_PC, OFFSET_TWO, enter, '0, !lvl1, lvl1);
		checkValue("pcA at new vector", pcA, wdata & 16'hFFFE);
		fetchStep(BASE_PC, OFFSET_TWO, leave, '0, 1'b0, 1'b0);
	endtask

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles, errors: %0d", cycles, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		pcAddrT retAddr;
		apbDataT rdata;
		logic err;
		seed = 32'hcb27;
		rstN = 1'b0;
		idleInputs();
		repeat (16) @(posedge CLK);
		#2;
		rstN = 1'b1;
		checkValue("pcA after reset", pcA, 16'h0000);

		repeat (6) fetchStep(BASE_PC, OFFSET_TWO, NEXT_SEQ, '0, 1'b0, 1'b0);
		checkValue("pcA after six fetches", pcA, 16'h000C);

		// Relative and absolute jumps, then stalls
		fetchStep(BASE_PC, OFFSET_OPERAND, NEXT_SEQ, 16'h0040, 1'b0, 1'b0);
		fetchStep(BASE_ZERO, OFFSET_OPERAND, NEXT_SEQ, 16'h0200, 1'b0, 1'b0);
		stallStep(1'b0, 1'b1);
		stallStep(1'b1, 1'b0);
		stallStep(1'b0, 1'b0);
		checkValue("pcA after stalls", pcA, 16'h0200);

		// Stalled loads leave the return registers at their reset value
		apbRead(REG_RET0, rdata, err);
		checkValue("return address 0 after stalls", rdata, 16'h0000);
		apbRead(REG_RET1, rdata, err);
		checkValue("return address 1 after stalls", rdata, 16'h0000);

		repeat (4) fetchStep(BASE_PC, OFFSET_OPERAND, NEXT_SEQ, pcAddrT'($random(seed)),
			1'b0, 1'b0);

		// Level 1 interrupt and return
		retAddr = modelPc + 16'h0002;
		fetchStep(BASE_PC, OFFSET_TWO, NEXT_INTV1, '0, 1'b0, 1'b1);
		checkValue("pcA at vector 1", pcA, VEC1_RESET);
		repeat (3) fetchStep(BASE_PC, OFFSET_TWO, NEXT_SEQ, '0, 1'b0, 1'b0);
		apbRead(REG_RET1, rdata, err);
		checkValue("return address 1", rdata, retAddr);
		fetchStep(BASE_PC, OFFSET_TWO, NEXT_INTR1, '0, 1'b0, 1'b0);
		checkValue("pcA after return 1", pcA, retAddr);

		// Level 1 nested inside level 0
		retAddr = modelPc + 16'h0002;
		fetchStep(BASE_PC, OFFSET_TWO, NEXT_INTV0, '0, 1'b1, 1'b0);
		checkValue("pcA at vector 0", pcA, VEC0_RESET);
		fetchStep(BASE_PC, OFFSET_TWO, NEXT_SEQ, '0, 1'b0, 1'b0);
		fetchStep(BASE_PC, OFFSET_TWO, NEXT_INTV1, '0, 1'b0, 1'b1);
		apbRead(REG_RET0, rdata, err);
		apbRead(REG_RET1, rdata, err);
		fetchStep(BASE_PC, OFFSET_TWO, NEXT_INTR1, '0, 1'b0, 1'b0);
		fetchStep(BASE_PC, OFFSET_TWO, NEXT_INTR0, '0, 1'b0, 1'b0);
		checkValue("pcA after return 0", pcA, retAddr);

		vectorCheck(REG_VEC0, NEXT_INTV0, NEXT_INTR0, 1'b0);
		vectorCheck(REG_VEC0, NEXT_INTV0, NEXT_INTR0, 1'b0);
		vectorCheck(REG_VEC1, NEXT_INTV1, NEXT_INTR1, 1'b1);
		vectorCheck(REG_VEC1, NEXT_INTV1, NEXT_INTR1, 1'b1);

		// Read-only and unmapped offsets
		apbWrite(REG_RET0, apbDataT'($random(seed)), err);
		checkFlag("pslverr on return 0 write", err, 1'b1);
		apbWrite(REG_RET1, apbDataT'($random(seed)), err);
		checkFlag("pslverr on return 1 write", err, 1'b1);
		apbRead(4'h2, rdata, err);
		checkFlag("pslverr on unmapped read", err, 1'b1);
		apbWrite(4'h6, 16'h1234, err);
		checkFlag("pslverr on unmapped write", err, 1'b1);
		apbRead(REG_RET0, rdata, err);
		checkFlag("pslverr on return 0 read", err, 1'b0);
		apbRead(REG_VEC0, rdata, err);
		apbRead(REG_VEC1, rdata, err);

		idleInputs();
		repeat (2) @(posedge CLK);
		$display("Errors: %0d, cycles: %0d", errors, cycles);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- design/forthPcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forthPcUnit
	import pcAddrPkg::*, pcCtrlPkg::*;
(
	input wire logic CLK,
	input wire logic rstN,

	// Fetch control
	input wire logic pcEn,
	input wire logic fetch,
	input wire logic ldInt0,
	input wire logic ldInt1,
	input wire baseSelT baseSel,
	input wire offsetSelT offsetSel,
	input wire nextSelT nextSel,
	input wire pcAddrT operand,

	// Instruction address
	output pcAddrT pcA,
	output pcAddrT pcANext,

	// APB slave
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire apbAddrT paddr,
	input wire apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr
);

	pcAddrT intVec0;
	pcAddrT intVec1;
	pcAddrT intRet0;
	pcAddrT intRet1;

	pcCtrlIf ctrlIf ();

	// Controller side of the bundle is the top-level pins
	assign ctrlIf.pcEn = pcEn;
	assign ctrlIf.fetch = fetch;
	assign ctrlIf.ldInt0 = ldInt0;
	assign ctrlIf.ldInt1 = ldInt1;
	assign ctrlIf.baseSel = baseSel;
	assign ctrlIf.offsetSel = offsetSel;
	assign ctrlIf.nextSel = nextSel;
	assign ctrlIf.operand = operand;

	pcVectorRegs regs_i (
		.CLK(CLK),
		.rstN(rstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.intRet0(intRet0),
		.intRet1(intRet1),
		.intVec0(intVec0),
		.intVec1(intVec1)
	);

	programCounter pc_i (
		.CLK(CLK),
		.rstN(rstN),
		.ctrl(ctrlIf.counter),
		.intVec0(intVec0),
		.intVec1(intVec1),
		.pcA(pcA),
		.pcANext(pcANext),
		.intRet0(intRet0),
		.intRet1(intRet1)
	);

endmodule

`default_nettype wire

//--- design/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter
	import pcAddrPkg::*, pcCtrlPkg::*;
(
	input wire logic CLK,
	input wire logic rstN,

	pcCtrlIf.counter ctrl,

	// Vectors from the register block
	input wire pcAddrT intVec0,
	input wire pcAddrT intVec1,

	output pcAddrT pcA,
	output pcAddrT pcANext,

	// Return addresses, readable over APB
	output pcAddrT intRet0,
	output pcAddrT intRet1
);

	pcAddrT pcQ;
	pcAddrT ret0Q;
	pcAddrT ret1Q;

	pcAddrT base;
	pcAddrT offset;
	pcAddrT seqSum;
	pcAddrT nextAddr;

	logic advance;

	// Base operand
	always_comb begin
		unique case (ctrl.baseSel)
			BASE_PC: base = pcQ;
			BASE_ZERO: base = '0;
			default: base = pcQ;
		endcase
	end

	// Offset operand
	always_comb begin
		unique case (ctrl.offsetSel)
			OFFSET_TWO: offset = PC_STEP;
			OFFSET_OPERAND: offset = ctrl.operand;
			default: offset = PC_STEP;
		endcase
	end

	// Wraps at 64K
	assign seqSum = base + offset;

	// Next address select
	always_comb begin
		unique case (ctrl.nextSel)
			NEXT_SEQ: nextAddr = seqSum;
			NEXT_INTV0: nextAddr = intVec0;
			NEXT_INTV1: nextAddr = intVec1;
			NEXT_INTR0: nextAddr = ret0Q;
			NEXT_INTR1: nextAddr = ret1Q;
			default: nextAddr = seqSum;
		endcase
	end

	// Both enables needed, otherwise everything stalls
	assign advance = ctrl.pcEn & ctrl.fetch;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pcQ <= PC_RESET;
		end else if (advance) begin
			pcQ <= nextAddr;
		end
	end

	// Return registers keep the address the interrupted code runs next
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			ret0Q <= '0;
			ret1Q <= '0;
		end else if (advance) begin
			if (ctrl.ldInt0) begin
				ret0Q <= seqSum;
			end
			if (ctrl.ldInt1) begin
				ret1Q <= seqSum;
			end
		end
	end

	assign pcA = pcQ;
	assign pcANext = nextAddr;
	assign intRet0 = ret0Q;
	assign intRet1 = ret1Q;

endmodule

`default_nettype wire

//--- design/pcVectorRegs.sv
`timescale 1ns/1ps
`default_nettype none

module pcVectorRegs
	import pcAddrPkg::*;
(
	input wire logic CLK,
	input wire logic rstN,

	// APB slave
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire apbAddrT paddr,
	input wire apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr,

	// Counter side
	input wire pcAddrT intRet0,
	input wire pcAddrT intRet1,
	output pcAddrT intVec0,
	output pcAddrT intVec1
);

	logic access;
	logic rdAccess;
	logic wrAccess;

	logic hitVec0;
	logic hitVec1;
	logic hitRet0;
	logic hitRet1;
	logic mapped;
	logic readOnly;

	pcAddrT vec0Q;
	pcAddrT vec1Q;

	// No wait states, so every access phase completes
	assign access = psel & penable;
	assign rdAccess = access & ~pwrite;
	assign wrAccess = access & pwrite;

	// Offset decode
	assign hitVec0 = (paddr == REG_VEC0);
	assign hitVec1 = (paddr == REG_VEC1);
	assign hitRet0 = (paddr == REG_RET0);
	assign hitRet1 = (paddr == REG_RET1);
	assign mapped = hitVec0 | hitVec1 | hitRet0 | hitRet1;
	assign readOnly = hitRet0 | hitRet1;

	// Vector registers, kept halfword aligned
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			vec0Q <= VEC0_RESET;
			vec1Q <= VEC1_RESET;
		end else if (wrAccess) begin
			if (hitVec0) begin
				vec0Q <= {pwdata[APB_DATA_W-1:1], 1'b0};
			end
			if (hitVec1) begin
				vec1Q <= {pwdata[APB_DATA_W-1:1], 1'b0};
			end
		end
	end

	// Read data only while a read is in its access phase
	always_comb begin
		prdata = '0;
		if (rdAccess) begin
			unique case (1'b1)
				hitVec0: prdata = vec0Q;
				hitVec1: prdata = vec1Q;
				hitRet0: prdata = intRet0;
				hitRet1: prdata = intRet1;
				default: prdata = '0;
			endcase
		end
	end

	assign pready = access;

	// Unmapped offset, or a write to a return register
	assign pslverr = access & (~mapped | (pwrite & readOnly));

	assign intVec0 = vec0Q;
	assign intVec1 = vec1Q;

endmodule

`default_nettype wire

//--- design/pcCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface pcCtrlIf
	import pcAddrPkg::*, pcCtrlPkg::*;
();

	// Fetch enables
	logic pcEn;
	logic fetch;

	// Return register load strobes
	logic ldInt0;
	logic ldInt1;

	// Address formation selects
	baseSelT baseSel;
	offsetSelT offsetSel;
	nextSelT nextSel;
	pcAddrT operand;

	modport controller (
		output pcEn,
		output fetch,
		output ldInt0,
		output ldInt1,
		output baseSel,
		output offsetSel,
		output nextSel,
		output operand
	);

	modport counter (
		input pcEn,
		input fetch,
		input ldInt0,
		input ldInt1,
		input baseSel,
		input offsetSel,
		input nextSel,
		input operand
	);

endinterface

`default_nettype wire

//--- design/pcCtrlPkg.sv
`default_nettype none

package pcCtrlPkg;

	// Left operand of the address adder
	typedef enum logic {
		BASE_PC   = 1'b0,
		BASE_ZERO = 1'b1
	} baseSelT;

	// Right operand of the address adder
	typedef enum logic {
		OFFSET_TWO     = 1'b0,
		OFFSET_OPERAND = 1'b1
	} offsetSelT;

	// Source of the next fetch address
	typedef enum logic [2:0] {
		NEXT_SEQ   = 3'd0,
		NEXT_INTV0 = 3'd1,
		NEXT_INTV1 = 3'd2,
		NEXT_INTR0 = 3'd3,
		NEXT_INTR1 = 3'd4
	} nextSelT;

endpackage

`default_nettype wire

//--- design/pcAddrPkg.sv
`default_nettype none

package pcAddrPkg;

	// Address and bus widths
	localparam int PC_ADDR_W = 16;
	localparam int APB_ADDR_W = 4;
	localparam int APB_DATA_W = 16;

	typedef logic [PC_ADDR_W-1:0] pcAddrT;
	typedef logic [APB_ADDR_W-1:0] apbAddrT;
	typedef logic [APB_DATA_W-1:0] apbDataT;

	// APB register map
	localparam apbAddrT REG_VEC0 = 4'h0;
	localparam apbAddrT REG_VEC1 = 4'h4;
	localparam apbAddrT REG_RET0 = 4'h8;
	localparam apbAddrT REG_RET1 = 4'hC;

	// Interrupt vectors after reset
	localparam pcAddrT VEC0_RESET = 16'h0004;
	localparam pcAddrT VEC1_RESET = 16'h0008;

	// Counter restarts here
	localparam pcAddrT PC_RESET = 16'h0000;

	// One 16-bit instruction per sequential fetch
	localparam pcAddrT PC_STEP = 16'h0002;

endpackage

`default_nettype wire
